/* hw/lut_cfg.svh */
`ifndef LUT_CFG_SVH
`define LUT_CFG_SVH

// Table element and databus word widths
`define LUT_ELEM_W 32
`define LUT_BUS_W  64

// External byte address
`define LUT_BUS_AW 32

// RAM word address, top bit is the bank in ping-pong mode
`define LUT_RAM_AW 9

// Element index is word bits plus one lane bit
`define LUT_IDX_W  9

// Burst length, beats minus one
`define LUT_LEN_W  8

`endif

/* hw/lut_pkg.sv */
`include "lut_cfg.svh"

package lut_pkg;

   typedef logic [`LUT_ELEM_W-1:0] elem_t;
   typedef logic [`LUT_BUS_W-1:0]  bus_word_t;
   typedef logic [`LUT_BUS_AW-1:0] bus_addr_t;
   typedef logic [`LUT_RAM_AW-1:0] ram_addr_t;
   typedef logic [`LUT_IDX_W-1:0]  idx_t;
   typedef logic [`LUT_LEN_W-1:0]  len_t;

   // Load configuration, sampled on run
   typedef struct packed {
      bus_addr_t ext_addr;
      ram_addr_t int_addr;
      ram_addr_t incr;
      len_t      length;
      logic      ping_pong;
      logic      disabled;
   } lut_cfg_t;

   // Table RAM write port
   typedef struct packed {
      logic      en;
      ram_addr_t addr;
      bus_word_t data;
   } ram_wr_t;

endpackage

/* hw/lut_ram.sv */
`include "lut_cfg.svh"

module lut_ram
   import lut_pkg::*;
(
   input  logic      clk,
   input  ram_wr_t   wr,
   input  ram_addr_t rd_addr,
   output bus_word_t rd_data
);

   localparam int DEPTH = 1 << `LUT_RAM_AW;

   bus_word_t mem [DEPTH];

   // Write port, fed by the loader
   always_ff @(posedge clk) begin
      if (wr.en) begin
         mem[wr.addr] <= wr.data;
      end
   end

   // Registered read port, fed by the reader
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

/* hw/lut_loader.sv */
`include "lut_cfg.svh"

module lut_loader
   import lut_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      run,
   input  lut_cfg_t  cfg,
   input  logic      bus_ready,
   input  bus_word_t bus_rdata,
   input  logic      bus_last,
   output logic      bus_valid,
   output bus_addr_t bus_addr,
   output len_t      bus_len,
   output logic      done,
   output ram_wr_t   wr,
   output logic      read_bank
);

   typedef enum logic {
      IDLE,
      FETCH
   } state_t;

   state_t    state;
   logic      start;
   logic      xfer;
   logic      bank;
   logic      pp_mode;
   ram_addr_t wr_ptr;
   ram_addr_t wr_addr_n;
   logic      wr_en;
   ram_addr_t wr_addr;
   bus_word_t wr_data;

   assign start = run && !cfg.disabled;
   assign xfer  = bus_valid && bus_ready;

   assign bus_valid = (state == FETCH);
   assign bus_len   = cfg.length;

   // A new run takes priority over the last beat in the burst FSM
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE: begin
               if (start) begin
                  state <= FETCH;
               end
            end
            FETCH: begin
               if (xfer && bus_last && !start) begin
                  state <= IDLE;
               end
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done <= 1'b1;
      end else if (start) begin
         done <= 1'b0;
      end else if (xfer && bus_last) begin
         done <= 1'b1;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bus_addr <= '0;
      end else if (start) begin
         bus_addr <= cfg.ext_addr;
      end
   end

   // Bank swaps on every run even when disabled
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bank    <= 1'b0;
         pp_mode <= 1'b0;
      end else if (run) begin
         bank    <= cfg.ping_pong ? !bank : 1'b0;
         pp_mode <= cfg.ping_pong;
      end
   end

   assign read_bank = pp_mode && !bank;

   // Write pointer steps by incr per accepted beat
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr <= '0;
      end else if (start) begin
         wr_ptr <= cfg.int_addr;
      end else if (xfer) begin
         wr_ptr <= wr_ptr + cfg.incr;
      end
   end

   always_comb begin
      wr_addr_n = wr_ptr;
      if (pp_mode) begin
         wr_addr_n[`LUT_RAM_AW-1] = bank;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_en <= 1'b0;
      end else begin
         wr_en <= xfer;
      end
   end

   always_ff @(posedge clk) begin
      if (xfer) begin
         wr_addr <= wr_addr_n;
         wr_data <= bus_rdata;
      end
   end

   assign wr = '{en: wr_en, addr: wr_addr, data: wr_data};

   // No bus request once the load is reported complete
   a_valid_not_done: assert property (
      @(posedge clk) disable iff (rst) !(bus_valid && done)
   );

   // A RAM write only follows a beat of a load in progress
   a_wr_in_load: assert property (
      @(posedge clk) disable iff (rst) wr.en |-> $past(!done)
   );

endmodule

/* hw/lut_reader.sv */
`include "lut_cfg.svh"

module lut_reader
   import lut_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  idx_t      index,
   input  logic      read_bank,
   output ram_addr_t rd_addr,
   input  bus_word_t rd_data,
   output elem_t     value
);

   localparam int LANES = `LUT_BUS_W / `LUT_ELEM_W;

   ram_addr_t           rd_addr_n;
   logic                lane_q0;
   logic                lane_q1;
   elem_t [LANES-1:0]   lanes;

   // Word part of the index, bank bit on top
   always_comb begin
      rd_addr_n = ram_addr_t'(index >> 1);
      rd_addr_n[`LUT_RAM_AW-1] = read_bank;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_addr <= '0;
      end else begin
         rd_addr <= rd_addr_n;
      end
   end

   // Lane bit follows the address and then the RAM read stage
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         lane_q0 <= 1'b0;
         lane_q1 <= 1'b0;
      end else begin
         lane_q0 <= index[0];
         lane_q1 <= lane_q0;
      end
   end

   assign lanes = rd_data;
   assign value = lanes[lane_q1];

   // An unknown lane means an undriven index two cycles back
   a_lane_known: assert property (
      @(posedge clk) disable iff (rst) !$isunknown(lane_q1)
   );

endmodule

/* hw/lut_top.sv */
`include "lut_cfg.svh"

module lut_top
   import lut_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      run,
   input  lut_cfg_t  cfg,
   output logic      done,
   output logic      bus_valid,
   output bus_addr_t bus_addr,
   output len_t      bus_len,
   input  logic      bus_ready,
   input  bus_word_t bus_rdata,
   input  logic      bus_last,
   input  idx_t      index,
   output elem_t     value
);

   ram_wr_t   wr;
   logic      read_bank;
   ram_addr_t rd_addr;
   bus_word_t rd_data;

   // Burst fetch and table write side
   lut_loader u_loader (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .cfg       (cfg),
      .bus_ready (bus_ready),
      .bus_rdata (bus_rdata),
      .bus_last  (bus_last),
      .bus_valid (bus_valid),
      .bus_addr  (bus_addr),
      .bus_len   (bus_len),
      .done      (done),
      .wr        (wr),
      .read_bank (read_bank)
   );

   lut_ram u_ram (
      .clk     (clk),
      .wr      (wr),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   // Lookup side, two cycles from index to value
   lut_reader u_reader (
      .clk       (clk),
      .rst       (rst),
      .index     (index),
      .read_bank (read_bank),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data),
      .value     (value)
   );

endmodule

/* tb/lut_checker.sv */
`include "lut_cfg.svh"

module lut_checker
   import lut_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      run,
   input  lut_cfg_t  cfg,
   input  logic      done,
   input  logic      bus_valid,
   input  bus_addr_t bus_addr,
   input  len_t      bus_len,
   input  logic      bus_ready,
   input  bus_word_t bus_rdata,
   input  logic      bus_last,
   input  idx_t      index,
   input  elem_t     value,
   output int        errors,
   output int        checks
);

   localparam int DEPTH = 1 << `LUT_RAM_AW;

   bus_word_t model_mem [DEPTH];
   logic      known [DEPTH];
   logic      exp_done;
   logic      exp_valid;
   logic      bank;
   logic      pp_mode;
   bus_addr_t ext_addr_q;
   len_t      len_q;
   ram_addr_t incr_q;
   ram_addr_t ptr;
   int        beats;
   logic      start;
   logic      xfer;
   // Write that lands in the RAM one edge after its beat
   logic      pend_en;
   ram_addr_t pend_addr;
   bus_word_t pend_data;
   ram_addr_t rd1_addr;
   logic      rd1_lane;
   logic      rd2_ok;
   elem_t     rd2_value;

   always @(posedge clk or posedge rst) begin
      if (rst) begin
         errors     = 0;
         checks     = 0;
         exp_done   = 1'b1;
         exp_valid  = 1'b0;
         bank       = 1'b0;
         pp_mode    = 1'b0;
         ext_addr_q = '0;
         len_q      = '0;
         incr_q     = '0;
         ptr        = '0;
         beats      = 0;
         pend_en    = 1'b0;
         rd1_addr   = '0;
         rd1_lane   = 1'b0;
         rd2_ok     = 1'b0;
         for (int i = 0; i < DEPTH; i++) begin
            known[i] = 1'b0;
         end
      end else begin
         start = run && !cfg.disabled;
         xfer  = bus_valid && bus_ready;

         if (done !== exp_done) begin
            $display("ERROR done: got %h expected %h", done, exp_done);
            errors++;
         end
         if (bus_valid !== exp_valid) begin
            $display("ERROR bus_valid: got %h expected %h", bus_valid, exp_valid);
            errors++;
         end
         if (bus_valid && done) begin
            $display("Bus request seen while the load is reported done");
            errors++;
         end
         if (bus_addr !== ext_addr_q) begin
            $display("ERROR bus_addr: got %h expected %h", bus_addr, ext_addr_q);
            errors++;
         end
         if (exp_valid && bus_len !== len_q) begin
            $display("ERROR bus_len: got %h expected %h", bus_len, len_q);
            errors++;
         end
         if (rd2_ok) begin
            checks++;
            if (value !== rd2_value) begin
               $display("ERROR value: got %h expected %h", value, rd2_value);
               errors++;
            end
         end

         // Two lookup stages, address then RAM word
         rd2_ok    = known[rd1_addr] && !(pend_en && pend_addr == rd1_addr);
         rd2_value = rd1_lane ? model_mem[rd1_addr][`LUT_BUS_W-1:`LUT_ELEM_W]
                              : model_mem[rd1_addr][`LUT_ELEM_W-1:0];
         rd1_addr  = {pp_mode && !bank, index[`LUT_IDX_W-1:1]};
         rd1_lane  = index[0];

         if (pend_en) begin
            model_mem[pend_addr] = pend_data;
            known[pend_addr]     = 1'b1;
         end
         pend_en = xfer;
         if (xfer) begin
            pend_addr = ptr;
            if (pp_mode) begin
               pend_addr[`LUT_RAM_AW-1] = bank;
            end
            pend_data = bus_rdata;
            ptr       = ptr + incr_q;
            beats++;
            if (bus_last && beats != int'(len_q) + 1) begin
               $display("Burst ended after %0d beats instead of %0d", beats, int'(len_q) + 1);
               errors++;
            end
         end

         if (start) begin
            exp_done   = 1'b0;
            exp_valid  = 1'b1;
            ext_addr_q = cfg.ext_addr;
            len_q      = cfg.length;
            incr_q     = cfg.incr;
            ptr        = cfg.int_addr;
            beats      = 0;
         end else if (xfer && bus_last) begin
            exp_done  = 1'b1;
            exp_valid = 1'b0;
         end
         // Bank state moves on any run
         if (run) begin
            bank    = cfg.ping_pong ? !bank : 1'b0;
            pp_mode = cfg.ping_pong;
         end
      end
   end

endmodule

/* tb/tb_lut.sv */
`include "lut_cfg.svh"

module tb_lut
   import lut_pkg::*;
();

   localparam int DONE_TIMEOUT = 2000;

   logic      clk;
   logic      rst;
   logic      run;
   lut_cfg_t  cfg;
   logic      done;
   logic      bus_valid;
   bus_addr_t bus_addr;
   len_t      bus_len;
   logic      bus_ready;
   bus_word_t bus_rdata;
   logic      bus_last;
   idx_t      index;
   elem_t     value;

   int         seed = 32'h9d6e;
   int         errors;
   int         checks;
   int         timeouts;
   logic       aborted;
   logic [8:0] beat_num;
   ram_addr_t  last_int;
   ram_addr_t  last_incr;
   len_t       last_len;

   lut_top uut (.*);

   lut_checker chk (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Beat number of the burst in flight, seen by the memory model
   always @(posedge clk or posedge rst) begin
      if (rst) begin
         beat_num <= '0;
      end else if (run && !cfg.disabled) begin
         beat_num <= '0;
      end else if (bus_valid && bus_ready) begin
         beat_num <= beat_num + 9'd1;
      end
   end

   function automatic logic [31:0] rand32();
      rand32 = $random(seed);
   endfunction

   // External memory contents, a function of address and beat
   function automatic bus_word_t bus_word(input bus_addr_t a, input logic [8:0] beat);
      logic [31:0] b;
      b = {23'd0, beat};
      bus_word = {a + (b << 3), (a ^ 32'h5a5a0000) + b * 32'h0101};
   endfunction

   function automatic lut_cfg_t fill_cfg(input ram_addr_t base);
      lut_cfg_t c;
      c.ext_addr  = 32'h0001_0000 | {20'd0, base, 3'd0};
      c.int_addr  = base;
      c.incr      = 9'd1;
      c.length    = 8'hff;
      c.ping_pong = 1'b0;
      c.disabled  = 1'b0;
      fill_cfg    = c;
   endfunction

   function automatic lut_cfg_t random_cfg(input logic pp, input logic dis);
      lut_cfg_t    c;
      logic [31:0] r;
      r           = rand32();
      c.ext_addr  = {r[31:3], 3'b000};
      r           = rand32();
      c.int_addr  = pp ? r[8:0] : {1'b0, r[7:0]};
      c.incr      = {5'd0, r[12:9]};
      c.length    = {1'b0, r[22:16]};
      c.ping_pong = pp;
      c.disabled  = dis;
      random_cfg  = c;
   endfunction

   // Half the picks land on words of the last load
   function automatic idx_t pick_index();
      logic [31:0] r;
      int          k;
      ram_addr_t   w;
      r = rand32();
      k = int'(r[15:8]) % (int'(last_len) + 1);
      w = last_int + ram_addr_t'(k) * last_incr;
      pick_index = r[0] ? {w[`LUT_IDX_W-2:0], r[1]} : r[24:16];
   endfunction

   // One cycle, with the memory model answering the databus
   task automatic step();
      logic [31:0] r;
      @(negedge clk);
      r         = rand32();
      bus_ready = (r[1:0] != 2'b00);
      bus_rdata = bus_word(bus_addr, beat_num);
      bus_last  = (beat_num == {1'b0, bus_len});
   endtask

   task automatic wait_done(input logic during);
      int n;
      n = 0;
      while (!done && n < DONE_TIMEOUT) begin
         step();
         if (during) begin
            index = pick_index();
         end
         n++;
      end
      if (!done) begin
         $display("Timeout waiting for done after %0d cycles", DONE_TIMEOUT);
         timeouts++;
         aborted = 1'b1;
      end
   endtask

   task automatic do_run(input lut_cfg_t c, input logic during);
      if (aborted) begin
         return;
      end
      cfg = c;
      run = 1'b1;
      step();
      run = 1'b0;
      if (c.disabled) begin
         repeat (2) step();
      end else begin
         last_int  = c.int_addr;
         last_incr = c.incr;
         last_len  = c.length;
         wait_done(during);
      end
   endtask

   task automatic lookups(input int n);
      if (aborted) begin
         return;
      end
      repeat (n) begin
         step();
         index = pick_index();
      end
      repeat (3) step();
   endtask

   initial begin
      rst       = 1'b1;
      run       = 1'b0;
      cfg       = '0;
      index     = '0;
      bus_ready = 1'b0;
      bus_rdata = '0;
      bus_last  = 1'b0;
      timeouts  = 0;
      aborted   = 1'b0;
      last_int  = '0;
      last_incr = '0;
      last_len  = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // Fill both halves so lookups have known contents
      do_run(fill_cfg(9'd0), 1'b0);
      do_run(fill_cfg(9'd256), 1'b0);
      lookups(64);

      for (int i = 0; i < 12 && !aborted; i++) begin
         do_run(random_cfg(1'b0, i % 5 == 4), 1'b0);
         lookups(48);
      end

      // Ping-pong, lookups keep running while the other bank loads
      for (int i = 0; i < 12 && !aborted; i++) begin
         do_run(random_cfg(1'b1, i % 4 == 3), 1'b1);
         lookups(32);
      end

      do_run(random_cfg(1'b0, 1'b0), 1'b0);
      lookups(32);
      repeat (4) step();

      $display("Lookups checked: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0 && checks > 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* vlog.f */
+incdir+hw
hw/lut_pkg.sv
hw/lut_ram.sv
hw/lut_loader.sv
hw/lut_reader.sv
hw/lut_top.sv
tb/lut_checker.sv
tb/tb_lut.sv

/* run.sh */
#!/bin/sh
# Build and run the lookup table testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_lut -f vlog.f -o tb_lut
./obj_dir/tb_lut | tee sim.log

if grep -q "Test completed successfully" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation did not pass, see sim.log"
   exit 1
fi
